// File: sram_tester_pkg.sv
// SRAM tester common definitions
package sram_tester_pkg;

  // Width of one SRAM word
  localparam int data_bits = 16;

  typedef logic [data_bits-1:0] data_t;

  // Data patterns, listed in test order
  typedef enum logic [2:0] {
    pat_addr     = 3'd0,
    pat_inv_addr = 3'd1,
    pat_checker  = 3'd2,
    pat_zeros    = 3'd3,
    pat_ones     = 3'd4
  } pattern_t;

  localparam pattern_t last_pattern = pat_ones;

  // Test sequencer states
  typedef enum logic [2:0] {
    st_write,
    st_read,
    st_check,
    st_next,
    st_pass,
    st_fail
  } test_state_t;

  // Bus controller states
  typedef enum logic [1:0] {
    cs_idle,
    cs_setup,
    cs_strobe,
    cs_hold
  } ctrl_state_t;

  // One access is setup, strobe and hold, done lands this many clocks after start
  localparam int cycle_cycles = 3;

  // Whatever setup and hold leave over goes to the strobe (1 to 4 clocks)
  localparam int strobe_cycles = cycle_cycles - 2;

endpackage

// File: sram_bus_ctrl.sv
// Asynchronous SRAM bus controller
`timescale 1ns/1ps

module sram_bus_ctrl #(
  parameter int addr_bits = 20
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic                   write,
  input  logic [addr_bits-1:0]   acc_addr,
  input  sram_tester_pkg::data_t acc_wdata,
  output sram_tester_pkg::data_t acc_rdata,
  output logic                   done,
  output logic [addr_bits-1:0]   addr_bus,
  inout  wire sram_tester_pkg::data_t data_bus,
  output logic                   ce_n,
  output logic                   we_n,
  output logic                   oe_n
);
  import sram_tester_pkg::*;

  ctrl_state_t state;
  logic        drive_q;
  logic [1:0]  strobe_cnt;
  data_t       wdata_q;
  data_t       rdata_q;

  // Only writes ever turn the bus around, so oe_n and the driver never overlap
  assign data_bus = drive_q ? wdata_q : 'z;

  // Live bus during hold, captured copy afterwards
  assign acc_rdata = (state == cs_hold && !drive_q) ? data_bus : rdata_q;
  assign done      = (state == cs_hold);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= cs_idle;
      ce_n       <= 1'b1;
      we_n       <= 1'b1;
      oe_n       <= 1'b1;
      drive_q    <= 1'b0;
      strobe_cnt <= '0;
    end else begin
      case (state)
        cs_idle: begin
          if (start) begin
            state   <= cs_setup;
            ce_n    <= 1'b0;
            drive_q <= write;
          end
        end
        cs_setup: begin
          state      <= cs_strobe;
          we_n       <= ~drive_q;
          oe_n       <= drive_q;
          strobe_cnt <= '0;
        end
        cs_strobe: begin
          if (strobe_cnt == 2'(strobe_cycles - 1)) begin
            state <= cs_hold;
            we_n  <= 1'b1;
          end else begin
            strobe_cnt <= strobe_cnt + 2'd1;
          end
        end
        cs_hold: begin
          state   <= cs_idle;
          ce_n    <= 1'b1;
          oe_n    <= 1'b1;
          drive_q <= 1'b0;
        end
        default: state <= cs_idle;
      endcase
    end
  end

  // Address and write data latched at start, read data at the end of hold
  always_ff @(posedge clk) begin
    if (state == cs_idle && start) begin
      addr_bus <= acc_addr;
      wdata_q  <= acc_wdata;
    end
    if (state == cs_hold && !drive_q) begin
      rdata_q <= data_bus;
    end
  end

endmodule

// File: pattern_gen.sv
// Test pattern data generator
`timescale 1ns/1ps

module pattern_gen #(
  parameter int addr_bits = 20
) (
  input  sram_tester_pkg::pattern_t pattern,
  input  logic [addr_bits-1:0]      addr,
  output sram_tester_pkg::data_t    data
);
  import sram_tester_pkg::*;

  data_t addr_word;
  data_t even_word;

  // Address folded into one word, zero-extended or truncated
  assign addr_word = data_bits'(addr);

  // 0x5555 for a 16-bit word
  assign even_word = {(data_bits / 2){2'b01}};

  always_comb begin
    case (pattern)
      pat_addr: begin
        data = addr_word;
      end
      pat_inv_addr: begin
        data = ~addr_word;
      end
      pat_checker: begin
        // Odd addresses get the inverted checker
        data = addr[0] ? ~even_word : even_word;
      end
      pat_zeros: begin
        data = '0;
      end
      pat_ones: begin
        data = '1;
      end
      default: begin
        data = '0;
      end
    endcase
  end

endmodule

// File: sram_tester.sv
// SRAM march test sequencer
`timescale 1ns/1ps

module sram_tester #(
  parameter int addr_bits = 20
) (
  input  logic                         clk,
  input  logic                         reset,
  output logic                         test_done,
  output logic                         test_pass,
  output sram_tester_pkg::pattern_t    pattern_state,
  output sram_tester_pkg::test_state_t test_state,
  output logic [addr_bits-1:0]         addr,
  output sram_tester_pkg::data_t       write_data,
  output sram_tester_pkg::data_t       read_data,
  output sram_tester_pkg::data_t       prev_expected_data,
  output sram_tester_pkg::data_t       prev_read_data,
  output logic [addr_bits-1:0]         addr_bus,
  inout  wire sram_tester_pkg::data_t  data_bus,
  output logic                         ce_n,
  output logic                         we_n,
  output logic                         oe_n
);
  import sram_tester_pkg::*;

  logic  start;
  logic  write;
  logic  done;
  logic  last_addr;
  logic  mismatch;
  data_t acc_rdata;

  // Same word is written and later expected back
  pattern_gen #(
    .addr_bits(addr_bits)
  ) pattern_gen_inst (
    .pattern(pattern_state),
    .addr   (addr),
    .data   (write_data)
  );

  sram_bus_ctrl #(
    .addr_bits(addr_bits)
  ) sram_bus_ctrl_inst (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .write    (write),
    .acc_addr (addr),
    .acc_wdata(write_data),
    .acc_rdata(acc_rdata),
    .done     (done),
    .addr_bus (addr_bus),
    .data_bus (data_bus),
    .ce_n     (ce_n),
    .we_n     (we_n),
    .oe_n     (oe_n)
  );

  assign write     = (test_state == st_write);
  assign last_addr = (addr == {addr_bits{1'b1}});
  assign mismatch  = (acc_rdata != write_data);

  assign test_done = (test_state == st_pass) || (test_state == st_fail);
  assign test_pass = (test_state != st_fail);

  // Next access is issued in the done cycle, so each address costs 4 clocks
  always_ff @(posedge clk) begin
    if (reset) begin
      test_state    <= st_next;
      pattern_state <= pat_addr;
      addr          <= '0;
      start         <= 1'b0;
    end else begin
      start <= 1'b0;
      case (test_state)
        st_next: begin
          addr       <= '0;
          start      <= 1'b1;
          test_state <= st_write;
        end
        st_write: begin
          if (done && last_addr) begin
            addr       <= '0;
            test_state <= st_read;
          end else if (done) begin
            addr  <= addr + 1'b1;
            start <= 1'b1;
          end
        end
        st_read: begin
          start      <= 1'b1;
          test_state <= st_check;
        end
        st_check: begin
          if (done) begin
            if (mismatch) begin
              test_state <= st_fail;
            end else if (!last_addr) begin
              addr  <= addr + 1'b1;
              start <= 1'b1;
            end else if (pattern_state == last_pattern) begin
              test_state <= st_pass;
            end else begin
              pattern_state <= pattern_t'(pattern_state + 3'd1);
              test_state    <= st_next;
            end
          end
        end
        st_pass, st_fail: begin
          // Results stay frozen until reset
        end
        default: test_state <= st_next;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (test_state == st_check && done) begin
      read_data <= acc_rdata;
      if (mismatch) begin
        prev_expected_data <= write_data;
        prev_read_data     <= acc_rdata;
      end
    end
  end

endmodule

// File: sram_tester_top.sv
// SRAM tester board top
`timescale 1ns/1ps

module sram_tester_top #(
  // Works from 8 bits upward
  parameter int addr_bits = 20
) (
  input  logic                   clk,
  input  logic                   reset,
  output logic                   led_done,
  output logic                   led_pass,
  output logic [addr_bits-1:0]   sram_addr,
  inout  wire sram_tester_pkg::data_t sram_data,
  output logic                   sram_ce_n,
  output logic                   sram_oe_n,
  output logic                   sram_we_n,
  output logic [7:0]             ba_pins,
  output logic [7:0]             dc_pins,
  output logic [7:0]             kl_pins,
  output logic [7:0]             hg_pins,
  output logic [7:0]             lk_pins
);
  import sram_tester_pkg::*;

  logic                 test_done;
  logic                 test_pass;
  pattern_t             pattern_state;
  logic [addr_bits-1:0] addr;
  logic [addr_bits-1:0] addr_rev;
  logic [2:0]           pattern_rev;
  logic [3:0]           ba_addr;
  data_t                write_data;
  data_t                read_data;
  data_t                prev_expected_data;
  data_t                prev_read_data;

  sram_tester #(
    .addr_bits(addr_bits)
  ) sram_tester_inst (
    .clk               (clk),
    .reset             (reset),
    .test_done         (test_done),
    .test_pass         (test_pass),
    .pattern_state     (pattern_state),
    .test_state        (),
    .addr              (addr),
    .write_data        (write_data),
    .read_data         (read_data),
    .prev_expected_data(prev_expected_data),
    .prev_read_data    (prev_read_data),
    .addr_bus          (sram_addr),
    .data_bus          (sram_data),
    .ce_n              (sram_ce_n),
    .we_n              (sram_we_n),
    .oe_n              (sram_oe_n)
  );

  assign led_done = test_done;
  assign led_pass = test_pass;

  // After a failure the banks show the captured words
  assign hg_pins = test_pass ? write_data[7:0] : prev_expected_data[7:0];
  assign lk_pins = test_pass ? read_data[7:0] : prev_read_data[7:0];

  // Displays are wired msb-first
  for (genvar i = 0; i < addr_bits; i++) begin : g_addr_rev
    assign addr_rev[i] = addr[addr_bits-1-i];
  end

  assign pattern_rev = {pattern_state[0], pattern_state[1], pattern_state[2]};
  assign ba_pins     = {ba_addr, 1'b0, pattern_rev};

  if (addr_bits >= 16) begin : g_wide_addr
    logic [19:0] rev20;

    // Missing upper bits read as zero below 20
    assign rev20   = 20'(addr_rev);
    assign ba_addr = rev20[3:0];
    assign dc_pins = rev20[11:4];
    assign kl_pins = rev20[19:12];
  end else begin : g_narrow_addr
    assign ba_addr = 4'b0;
    assign dc_pins = 8'(addr_rev[addr_bits-1:addr_bits/2]);
    assign kl_pins = 8'(addr_rev[addr_bits/2-1:0]);
  end

endmodule

// File: sram_model.sv
// Behavioural asynchronous SRAM
`timescale 1ns/1ps

module sram_model #(
  parameter int addr_bits = 8
) (
  input  logic [addr_bits-1:0]        addr,
  inout  wire sram_tester_pkg::data_t data,
  input  logic                        ce_n,
  input  logic                        we_n,
  input  logic                        oe_n,
  input  logic                        fault_en,
  input  logic [addr_bits-1:0]        fault_addr,
  input  logic [3:0]                  fault_bit,
  input  logic                        fault_val
);
  import sram_tester_pkg::*;

  data_t mem [2**addr_bits];
  data_t read_word;

  // One stuck bit, seen only on reads
  always_comb begin
    read_word = mem[addr];
    if (fault_en && addr == fault_addr) begin
      read_word[fault_bit] = fault_val;
    end
  end

  assign data = (!ce_n && !oe_n && we_n) ? read_word : 'z;

  // Write lands on the rising edge of we_n
  always @(posedge we_n) begin
    if (ce_n == 1'b0) begin
      mem[addr] <= data;
    end
  end

endmodule

// File: sram_tester_properties.sv
// SRAM pin and status assertions
`timescale 1ns/1ps

module sram_tester_properties #(
  parameter int addr_bits = 8
) (
  input logic                 clk,
  input logic                 reset,
  input logic [addr_bits-1:0] sram_addr,
  input logic                 sram_ce_n,
  input logic                 sram_we_n,
  input logic                 sram_oe_n,
  input logic                 led_done
);

  we_oe_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(!sram_we_n && !sram_oe_n))
    else $error("we_n and oe_n are low together");

  we_needs_ce: assert property (@(posedge clk) disable iff (reset)
    !sram_we_n |-> !sram_ce_n)
    else $error("we_n is low while ce_n is high");

  addr_stable_in_write: assert property (@(posedge clk) disable iff (reset)
    !sram_we_n |-> $stable(sram_addr))
    else $error("sram_addr changes while we_n is low");

  // Only a reset may clear the done flag
  done_holds: assert property (@(posedge clk) disable iff (reset)
    led_done |=> (led_done || reset))
    else $error("led_done fell without a reset");

endmodule

bind sram_tester_top sram_tester_properties #(
  .addr_bits(addr_bits)
) sram_tester_properties_inst (
  .clk      (clk),
  .reset    (reset),
  .sram_addr(sram_addr),
  .sram_ce_n(sram_ce_n),
  .sram_we_n(sram_we_n),
  .sram_oe_n(sram_oe_n),
  .led_done (led_done)
);

// File: tb_sram_tester.sv
// SRAM tester testbench
`timescale 1ns/1ps

module tb_sram_tester;
  import sram_tester_pkg::*;

  localparam int addr_bits = 8;
  localparam int rows = 6;
  localparam int row_cycles = 10 * 256 * 4 + 40;

  logic                 clk;
  logic                 reset;
  wire data_t           sram_data;
  logic [addr_bits-1:0] sram_addr;
  logic                 sram_ce_n;
  logic                 sram_oe_n;
  logic                 sram_we_n;
  logic                 led_done;
  logic                 led_pass;
  logic [7:0]           ba_pins;
  logic [7:0]           dc_pins;
  logic [7:0]           kl_pins;
  logic [7:0]           hg_pins;
  logic [7:0]           lk_pins;
  logic                 fault_en;
  logic [addr_bits-1:0] fault_addr;
  logic [3:0]           fault_bit;
  logic                 fault_val;

  // Stimulus columns
  logic       row_en   [rows];
  logic [7:0] row_addr [rows];
  logic [3:0] row_bit  [rows];
  logic       row_val  [rows];
  // Expected columns
  logic       exp_pass [rows];
  logic [2:0] exp_pat  [rows];
  logic [7:0] exp_addr [rows];
  data_t      exp_word [rows];
  data_t      exp_read [rows];

  logic [31:0] lfsr;
  int          error_count;
  int          check_count;

  sram_tester_top #(
    .addr_bits(addr_bits)
  ) sram_tester_top_inst (
    .clk      (clk),
    .reset    (reset),
    .led_done (led_done),
    .led_pass (led_pass),
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_ce_n(sram_ce_n),
    .sram_oe_n(sram_oe_n),
    .sram_we_n(sram_we_n),
    .ba_pins  (ba_pins),
    .dc_pins  (dc_pins),
    .kl_pins  (kl_pins),
    .hg_pins  (hg_pins),
    .lk_pins  (lk_pins)
  );

  sram_model #(
    .addr_bits(addr_bits)
  ) sram_model_inst (
    .addr      (sram_addr),
    .data      (sram_data),
    .ce_n      (sram_ce_n),
    .we_n      (sram_we_n),
    .oe_n      (sram_oe_n),
    .fault_en  (fault_en),
    .fault_addr(fault_addr),
    .fault_bit (fault_bit),
    .fault_val (fault_val)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Word each pattern leaves at an address
  function automatic data_t pattern_word(input int pat, input logic [7:0] a);
    case (pat)
      0: return {8'h00, a};
      1: return {8'hff, ~a};
      2: return a[0] ? 16'haaaa : 16'h5555;
      3: return 16'h0000;
      default: return 16'hffff;
    endcase
  endfunction

  function automatic logic [7:0] reverse_byte(input logic [7:0] v);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) begin
      r[i] = v[7-i];
    end
    return r;
  endfunction

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic set_row(input int r, input logic en, input logic [7:0] a,
                         input logic [3:0] b, input logic v);
    row_en[r]   = en;
    row_addr[r] = a;
    row_bit[r]  = b;
    row_val[r]  = v;
  endtask

  // First pattern whose word at the faulty address disagrees with the stuck value
  task automatic fill_expected(input int r);
    data_t w;
    exp_pass[r] = 1'b1;
    exp_pat[r]  = 3'd4;
    exp_addr[r] = 8'hff;
    exp_word[r] = pattern_word(4, 8'hff);
    exp_read[r] = exp_word[r];
    for (int p = 0; p < 5; p++) begin
      w = pattern_word(p, row_addr[r]);
      if (row_en[r] && exp_pass[r] && w[row_bit[r]] != row_val[r]) begin
        exp_pass[r] = 1'b0;
        exp_pat[r]  = 3'(p);
        exp_addr[r] = row_addr[r];
        exp_word[r] = w;
        exp_read[r] = w;
        exp_read[r][row_bit[r]] = row_val[r];
      end
    end
  endtask

  task automatic reset_for_row(input int r);
    @(posedge clk);
    reset      <= 1'b1;
    fault_en   <= row_en[r];
    fault_addr <= row_addr[r];
    fault_bit  <= row_bit[r];
    fault_val  <= row_val[r];
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("ce_n in reset", sram_ce_n, 1'b1);
    check_value("we_n in reset", sram_we_n, 1'b1);
    check_value("oe_n in reset", sram_oe_n, 1'b1);
    @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic run_row(input int r);
    int         cycles;
    logic       pass_dropped;
    logic [7:0] rev;
    cycles = 0;
    pass_dropped = 1'b0;
    reset_for_row(r);
    @(negedge clk);
    check_value("led_done after reset", led_done, 1'b0);
    check_value("led_pass after reset", led_pass, 1'b1);
    while (led_done !== 1'b1 && cycles < row_cycles) begin
      if (led_pass !== 1'b1) begin
        pass_dropped = 1'b1;
      end
      @(negedge clk);
      cycles++;
    end
    check_value("led_pass low while running", pass_dropped, 1'b0);
    if (led_done !== 1'b1) begin
      error_count++;
      $display("Row %0d never finished, led_done stayed low", r);
    end else begin
      rev = reverse_byte(exp_addr[r]);
      check_value("led_pass", led_pass, exp_pass[r]);
      check_value("ba_pins", ba_pins, {5'b0, exp_pat[r][0], exp_pat[r][1], exp_pat[r][2]});
      check_value("dc_pins", dc_pins, {4'b0, rev[7:4]});
      check_value("kl_pins", kl_pins, {4'b0, rev[3:0]});
      check_value("hg_pins", hg_pins, exp_word[r][7:0]);
      check_value("lk_pins", lk_pins, exp_read[r][7:0]);
    end
  endtask

  initial begin
    logic [31:0] rnd_addr;
    logic [31:0] rnd_bit;
    logic [31:0] rnd_val;
    reset = 1'b1;
    fault_en = 1'b0;
    fault_addr = '0;
    fault_bit = '0;
    fault_val = 1'b0;
    error_count = 0;
    check_count = 0;
    lfsr = 32'd93915;
    set_row(0, 1'b0, 8'd0, 4'd0, 1'b0);
    set_row(1, 1'b1, 8'd3, 4'd0, 1'b0);
    set_row(2, 1'b1, 8'd0, 4'd15, 1'b1);
    set_row(3, 1'b1, 8'd255, 4'd4, 1'b1);
    set_row(4, 1'b1, 8'd128, 4'd7, 1'b0);
    rnd_addr = draw_bits(8);
    rnd_bit = draw_bits(4);
    rnd_val = draw_bits(1);
    set_row(5, 1'b1, rnd_addr[7:0], rnd_bit[3:0], rnd_val[0]);
    for (int r = 0; r < rows; r++) begin
      fill_expected(r);
    end
    for (int r = 0; r < rows; r++) begin
      run_row(r);
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Twice the worst case of every row
  initial begin
    repeat (2 * rows * row_cycles) @(posedge clk);
    $display("Watchdog expired before all rows finished");
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: sim.f
sram_tester_pkg.sv
sram_bus_ctrl.sv
pattern_gen.sv
sram_tester.sv
sram_tester_top.sv
sram_model.sv
sram_tester_properties.sv
tb_sram_tester.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_sram_tester
FILELIST  = sim.f
LOG       = sim.log
FAIL_MSG  = Testbench failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
